/* common/mulPkg.sv */
package mulPkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int opWidth   = 16;                  // Input operand from the command word
    localparam int extWidth  = 17;                  // Operand after sign or zero extension
    localparam int prodWidth = 2 * extWidth;        // Full core product, 34 bits
    localparam int resWidth  = 32;                  // Accumulator and result
    localparam int opcWidth  = 4;                   // Opcode field

    // Core internals
    localparam int mcWidth   = extWidth + 1;        // Multiplicand plus sign guard bit
    localparam int preWidth  = prodWidth + 2;       // Product register with a guard bit at each end

    ////////////////////
    // Booth sequencing
    ////////////////////

    // One shift step per extended operand bit, no run skipping
    localparam int boothSteps = extWidth;
    localparam int cntWidth   = 5;                  // Holds boothSteps

    ////////////////////
    // Opcodes
    ////////////////////

    // Zero and 5..15 are illegal and come back as a command error
    localparam logic [opcWidth-1:0] opMul   = 4'd1; // Signed 16x16
    localparam logic [opcWidth-1:0] opMulU  = 4'd2; // Unsigned 16x16
    localparam logic [opcWidth-1:0] opMac   = 4'd3; // Signed multiply, add into accumulator
    localparam logic [opcWidth-1:0] opLdAcc = 4'd4; // Load accumulator

    ////////////////////
    // Command word
    ////////////////////

    // 36-bit command, opcode always in the top nibble
    //   operand view: multiply, unsigned multiply, accumulate
    //   load view:    load accumulator, 32-bit value below the opcode
    typedef union packed
    {
        struct packed
        {
            logic [opcWidth-1:0] opcode;   // Shared position with ldv.opcode
            logic [opWidth-1:0]  mcand;    // Multiplicand
            logic [opWidth-1:0]  mplier;   // Multiplier
        } opv;

        struct packed
        {
            logic [opcWidth-1:0] opcode;
            logic [resWidth-1:0] ldValue;  // New accumulator contents
        } ldv;
    } cmdWord;

endpackage

/* design/cmdDecode.sv */
`timescale 1ns/1ps

module cmdDecode
(
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          start,     // One-cycle strobe with cmd
    input  mulPkg::cmdWord                cmd,
    input  logic                          done,      // End of operation from result stage
    output logic                          busy,
    output logic                          mulLd,     // Kick the Booth core
    output logic [mulPkg::extWidth-1:0]   mulA,      // Extended multiplicand
    output logic [mulPkg::extWidth-1:0]   mulB,      // Extended multiplier
    output logic                          accLd,     // Load accumulator pulse
    output logic [mulPkg::resWidth-1:0]   accVal,
    output logic                          badOp,     // Illegal opcode pulse
    output logic [mulPkg::opcWidth-1:0]   opHeld     // Opcode of the running command
);

logic                          accept;      // Start taken on this edge
logic                          isMul;
logic                          isMulU;
logic                          isMac;
logic                          isLdAcc;
logic                          isLegal;
logic                          signExt;     // Sign vs zero extension
logic [mulPkg::extWidth-1:0]   extA;
logic [mulPkg::extWidth-1:0]   extB;

////////////////////
// Opcode decode
////////////////////

// Same opcode bits in both views, operand view used here
always_comb
begin
    isMul   = 1'b0;
    isMulU  = 1'b0;
    isMac   = 1'b0;
    isLdAcc = 1'b0;
    case (cmd.opv.opcode)
        mulPkg::opMul:   isMul   = 1'b1;
        mulPkg::opMulU:  isMulU  = 1'b1;
        mulPkg::opMac:   isMac   = 1'b1;
        mulPkg::opLdAcc: isLdAcc = 1'b1;
        default:         ;                  // Flags stay clear
    endcase
    isLegal = isMul | isMulU | isMac | isLdAcc;
end

// Idle, or finishing right now, so back-to-back commands lose no cycle
assign accept  = start & (~busy | done);

// Unsigned multiply pads with zero, everything else copies the sign
assign signExt = isMul | isMac;
assign extA    = {signExt & cmd.opv.mcand[mulPkg::opWidth-1], cmd.opv.mcand};
assign extB    = {signExt & cmd.opv.mplier[mulPkg::opWidth-1], cmd.opv.mplier};

////////////////////
// Control
////////////////////

always_ff @(posedge clk)
begin
    if (!rstN)
    begin
        busy   <= 1'b0;
        mulLd  <= 1'b0;
        accLd  <= 1'b0;
        badOp  <= 1'b0;
        opHeld <= '0;
    end
    else
    begin
        // Exactly one of these per accepted start
        mulLd <= accept & (isMul | isMulU | isMac);
        accLd <= accept & isLdAcc;
        badOp <= accept & ~isLegal;

        if (accept)
            busy <= 1'b1;
        else if (done)
            busy <= 1'b0;                   // Drops on the done edge

        if (accept)
            opHeld <= cmd.opv.opcode;       // Held for the result stage
    end
end

// Operand and load payload, only meaningful with its pulse
always_ff @(posedge clk)
begin
    if (accept)
    begin
        mulA   <= extA;
        mulB   <= extB;
        accVal <= cmd.ldv.ldValue;          // Load view of the same word
    end
end

endmodule

/* booth/boothCore.sv */
`timescale 1ns/1ps

module boothCore
(
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          ld,          // Load operands and start
    input  logic [mulPkg::extWidth-1:0]   m,           // Multiplicand
    input  logic [mulPkg::extWidth-1:0]   r,           // Multiplier
    output logic                          prodValid,   // One cycle after the last step
    output logic [mulPkg::prodWidth-1:0]  prod         // m * r, signed
);

logic [mulPkg::cntWidth-1:0]  cnt;          // Steps left, zero when idle
logic [mulPkg::mcWidth-1:0]   mReg;         // Multiplicand with sign guard
logic [mulPkg::preWidth-1:0]  prodReg;      // Upper half, multiplier, low guard bit
logic [mulPkg::mcWidth-1:0]   upper;        // Current upper half of prodReg
logic [mulPkg::mcWidth-1:0]   sum;          // Upper half after add/sub
logic                         lastStep;

assign upper    = prodReg[mulPkg::preWidth-1 -: mulPkg::mcWidth];
assign lastStep = (cnt == mulPkg::cntWidth'(1));

////////////////////
// Step counter
////////////////////

always_ff @(posedge clk)
begin
    if (!rstN)
        cnt <= '0;
    else if (ld)
        cnt <= mulPkg::cntWidth'(mulPkg::boothSteps);   // A new load restarts
    else if (|cnt)
        cnt <= cnt - 1'b1;
end

// Guard bit keeps the most negative multiplicand from flipping sign on subtract
always_ff @(posedge clk)
begin
    if (ld)
        mReg <= {m[mulPkg::extWidth-1], m};
end

////////////////////
// Booth step
////////////////////

// Recode on the pair {current bit, previous bit}
always_comb
begin
    case (prodReg[1:0])
        2'b01:   sum = upper + mReg;        // End of a run of ones
        2'b10:   sum = upper - mReg;        // Start of a run of ones
        default: sum = upper;               // Inside a run, nothing to add
    endcase
end

// Arithmetic shift right by one per step
always_ff @(posedge clk)
begin
    if (ld)
        prodReg <= {{mulPkg::mcWidth{1'b0}}, r, 1'b0};
    else if (|cnt)
        prodReg <= {sum[mulPkg::mcWidth-1], sum, prodReg[mulPkg::extWidth:1]};
end

////////////////////
// Output
////////////////////

// Final shift taken straight from sum, both guard bits dropped
always_ff @(posedge clk)
begin
    if (lastStep)
        prod <= {sum, prodReg[mulPkg::extWidth:2]};
end

always_ff @(posedge clk)
begin
    if (!rstN)
        prodValid <= 1'b0;
    else
        prodValid <= lastStep;              // Lines up with prod
end

endmodule

/* design/accResult.sv */
`timescale 1ns/1ps

module accResult
(
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          prodValid,   // Core product ready
    input  logic [mulPkg::prodWidth-1:0]  prod,
    input  logic                          accLd,       // Load accumulator command
    input  logic [mulPkg::resWidth-1:0]   accVal,
    input  logic                          badOp,       // Illegal opcode
    input  logic [mulPkg::opcWidth-1:0]   opHeld,      // Which multiply is running
    output logic                          done,
    output logic                          cmdErr,
    output logic [mulPkg::resWidth-1:0]   result,
    output logic                          accOvf       // Sticky signed overflow
);

logic [mulPkg::resWidth-1:0]  acc;          // Running accumulator, wraps
logic [mulPkg::resWidth-1:0]  prodLow;      // Low product bits, signed 16x16 fits
logic [mulPkg::resWidth-1:0]  accSum;
logic                         isMac;
logic                         sumOvf;

assign prodLow = prod[mulPkg::resWidth-1:0];
assign isMac   = (opHeld == mulPkg::opMac);
assign accSum  = acc + prodLow;

// Same input signs, different result sign
assign sumOvf  = (acc[mulPkg::resWidth-1] == prodLow[mulPkg::resWidth-1]) &&
                 (accSum[mulPkg::resWidth-1] != acc[mulPkg::resWidth-1]);

////////////////////
// Status pulses
////////////////////

always_ff @(posedge clk)
begin
    if (!rstN)
    begin
        done   <= 1'b0;
        cmdErr <= 1'b0;
    end
    else
    begin
        done   <= prodValid | accLd | badOp;    // One cycle after any ending event
        cmdErr <= badOp;                        // Only ever alongside done
    end
end

////////////////////
// Accumulator and result
////////////////////

// Bad opcode falls through, result and acc unchanged
always_ff @(posedge clk)
begin
    if (!rstN)
    begin
        acc    <= '0;
        result <= '0;
        accOvf <= 1'b0;
    end
    else if (accLd)
    begin
        acc    <= accVal;
        result <= accVal;                       // Echo the loaded value
    end
    else if (prodValid)
    begin
        if (isMac)
        begin
            acc    <= accSum;
            result <= accSum;
            if (sumOvf)
                accOvf <= 1'b1;                 // Held until reset
        end
        else
        begin
            result <= prodLow;                  // Plain multiply, acc untouched
        end
    end
end

endmodule

/* design/mulUnit.sv */
`timescale 1ns/1ps

module mulUnit
(
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          start,
    input  mulPkg::cmdWord                cmd,
    output logic                          busy,
    output logic                          done,
    output logic                          cmdErr,
    output logic [mulPkg::resWidth-1:0]   result,
    output logic                          accOvf
);

// Decoder to core
logic                          mulLd;
logic [mulPkg::extWidth-1:0]   mulA;
logic [mulPkg::extWidth-1:0]   mulB;

// Decoder to result stage
logic [mulPkg::opcWidth-1:0]   opHeld;
logic                          accLd;
logic [mulPkg::resWidth-1:0]   accVal;
logic                          badOp;

// Core to result stage
logic                          prodValid;
logic [mulPkg::prodWidth-1:0]  prod;

////////////////////
// Decode
////////////////////

cmdDecode uDecode
(
    .clk    (clk),
    .rstN   (rstN),
    .start  (start),
    .cmd    (cmd),
    .done   (done),         // Frees busy
    .busy   (busy),
    .mulLd  (mulLd),
    .mulA   (mulA),
    .mulB   (mulB),
    .accLd  (accLd),
    .accVal (accVal),
    .badOp  (badOp),
    .opHeld (opHeld)
);

////////////////////
// Execute
////////////////////

boothCore uBooth
(
    .clk       (clk),
    .rstN      (rstN),
    .ld        (mulLd),
    .m         (mulA),
    .r         (mulB),
    .prodValid (prodValid),
    .prod      (prod)
);

// Result
accResult uResult
(
    .clk       (clk),
    .rstN      (rstN),
    .prodValid (prodValid),
    .prod      (prod),
    .accLd     (accLd),
    .accVal    (accVal),
    .badOp     (badOp),
    .opHeld    (opHeld),
    .done      (done),
    .cmdErr    (cmdErr),
    .result    (result),
    .accOvf    (accOvf)
);

endmodule

/* tests/clkGen.sv */
`timescale 1ns/1ps

module clkGen
(
    output logic clk,
    output logic rstN
);

// 10 ns period
initial
begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// Reset low over the first two rising edges, released just after the second
initial
begin
    rstN = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
end

endmodule

/* tests/mulUnit_chk.sv */
`timescale 1ns/1ps

module mulUnitChk
(
    input  logic clk,
    input  logic rstN,
    input  logic busy,
    input  logic done,
    input  logic cmdErr
);

int errCount = 0;   // Failures so far, polled by the testbench

////////////////////
// Output protocol
////////////////////

doneOneCycle: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
    else
    begin
        errCount++;
        $error("done stayed high for more than one cycle");
    end

errWithDone: assert property (@(posedge clk) disable iff (!rstN) cmdErr |-> done)
    else
    begin
        errCount++;
        $error("cmdErr seen without done");
    end

// Busy only drops on the edge that ends the done cycle
doneWhileBusy: assert property (@(posedge clk) disable iff (!rstN) done |-> busy)
    else
    begin
        errCount++;
        $error("done seen while the unit was idle");
    end

idleAfterReset: assert property (@(posedge clk) !rstN |=> (!busy && !done))
    else
    begin
        errCount++;
        $error("busy or done high in the cycle after reset");
    end

endmodule

bind mulUnit mulUnitChk uChk
(
    .clk    (clk),
    .rstN   (rstN),
    .busy   (busy),
    .done   (done),
    .cmdErr (cmdErr)
);

/* tests/mulUnitTb.sv */
`timescale 1ns/1ps

module mulUnitTb;

localparam int timeoutCycles = 50;   // Per wait loop
localparam int mulLatency    = 20;   // Sampling edge to done, core operations
localparam int shortLatency  = 2;    // Load accumulator and illegal opcodes

typedef struct
{
    mulPkg::cmdWord  cmd;
    logic [31:0]     expRes;
    logic            expErr;
    logic            expOvf;
} stimRow;

logic                         clk;
logic                         rstN;
logic                         start;
mulPkg::cmdWord               cmd;
logic                         busy;
logic                         done;
logic                         cmdErr;
logic [mulPkg::resWidth-1:0]  result;
logic                         accOvf;

stimRow       rows[$];
logic [31:0]  rngState = 32'd51;
logic [31:0]  modelAcc = '0;     // Reference accumulator
logic         modelOvf = 1'b0;   // Sticky, like the DUT flag
logic [31:0]  modelRes = '0;     // Result holds its value on a bad opcode

clkGen uClk (.clk(clk), .rstN(rstN));

mulUnit dut
(
    .clk    (clk),
    .rstN   (rstN),
    .start  (start),
    .cmd    (cmd),
    .busy   (busy),
    .done   (done),
    .cmdErr (cmdErr),
    .result (result),
    .accOvf (accOvf)
);

////////////////////
// Helpers
////////////////////

function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
endfunction

function automatic mulPkg::cmdWord makeOp(input logic [3:0] opc, input logic [15:0] a,
                                          input logic [15:0] b);
    mulPkg::cmdWord c;
    c.opv.opcode = opc;
    c.opv.mcand  = a;
    c.opv.mplier = b;
    return c;
endfunction

function automatic mulPkg::cmdWord makeLoad(input logic [31:0] v);
    mulPkg::cmdWord c;
    c.ldv.opcode  = mulPkg::opLdAcc;
    c.ldv.ldValue = v;
    return c;
endfunction

// Reference model, appends one row with its expected outcome
task automatic addRow(input mulPkg::cmdWord c);
    stimRow              row;
    logic signed [31:0]  sProd;
    logic [32:0]         wide;
    sProd      = $signed(c.opv.mcand) * $signed(c.opv.mplier);
    row.cmd    = c;
    row.expErr = 1'b0;
    case (c.opv.opcode)
        mulPkg::opMul:   modelRes = sProd;
        mulPkg::opMulU:  modelRes = {16'h0, c.opv.mcand} * {16'h0, c.opv.mplier};
        mulPkg::opMac:
        begin
            wide = {modelAcc[31], modelAcc} + {sProd[31], sProd};   // One extra sign bit
            if (wide[32] != wide[31])
                modelOvf = 1'b1;
            modelAcc = wide[31:0];                                  // Wraps
            modelRes = modelAcc;
        end
        mulPkg::opLdAcc:
        begin
            modelAcc = c.ldv.ldValue;
            modelRes = modelAcc;
        end
        default: row.expErr = 1'b1;   // No state change
    endcase
    row.expRes = modelRes;
    row.expOvf = modelOvf;
    rows.push_back(row);
endtask

task automatic stopOnError();
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first error");
endtask

task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
        $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        stopOnError();
    end
endtask

// Strobe is driven 1 ns after an edge, the following edge (E0) samples it
task automatic pulseStart(input mulPkg::cmdWord c);
    @(posedge clk);
    #1;
    start = 1'b1;
    cmd   = c;
    @(posedge clk);
    #1;
    start = 1'b0;
endtask

// Outputs sampled on the falling edge, count 1 is the cycle after E0
task automatic waitDone(output int cycles);
    cycles = 0;
    do
    begin
        @(negedge clk);
        cycles++;
    end
    while (!done && cycles < timeoutCycles);
    assert (done)
    else
    begin
        $display("Timeout: done never came within %0d cycles of the start", timeoutCycles);
        stopOnError();
    end
endtask

task automatic checkBoundAsserts();
    assert (dut.uChk.errCount == 0)
    else
    begin
        $display("Bound checker reported %0d assertion failures", dut.uChk.errCount);
        stopOnError();
    end
endtask

////////////////////
// Main sequence
////////////////////

initial
begin
    int              lat;
    int              expLat;
    int              waitCnt;
    logic [3:0]      opc;
    logic [31:0]     rnd;
    start = 1'b0;
    cmd   = '0;

    // Signed and unsigned corners
    addRow(makeOp(mulPkg::opMul, 16'd3, 16'd5));
    addRow(makeOp(mulPkg::opMul, 16'hFFFF, 16'h0007));
    addRow(makeOp(mulPkg::opMul, 16'h8000, 16'h8000));   // Most negative squared
    addRow(makeOp(mulPkg::opMul, 16'h8000, 16'hFFFF));
    addRow(makeOp(mulPkg::opMul, 16'h7FFF, 16'h8000));
    addRow(makeOp(mulPkg::opMulU, 16'hFFFF, 16'hFFFF));
    addRow(makeOp(mulPkg::opMulU, 16'h8000, 16'h0002));
    addRow(makeOp(mulPkg::opMulU, 16'h0000, 16'h1234));
    // Accumulate, overflow first appears on the 0x7FFF square
    addRow(makeLoad(32'h0000_0010));
    addRow(makeOp(mulPkg::opMac, 16'd2, 16'd3));
    addRow(makeOp(mulPkg::opMac, 16'hFFFC, 16'd5));
    addRow(makeLoad(32'h7FFF_0000));
    addRow(makeOp(mulPkg::opMac, 16'h7FFF, 16'h7FFF));
    addRow(makeOp(mulPkg::opMac, 16'd1, 16'd1));
    // Illegal opcodes, then proof that acc is untouched
    addRow(makeOp(4'h0, 16'h1234, 16'h5678));
    addRow(makeOp(4'hF, 16'hFFFF, 16'hFFFF));
    addRow(makeOp(mulPkg::opMac, 16'd1, 16'd1));

    for (int i = 0; i < 16; i++)
    begin
        rnd = nextRandom();
        case (rnd[1:0])
            2'd0:    opc = mulPkg::opMul;
            2'd1:    opc = mulPkg::opMulU;
            2'd2:    opc = mulPkg::opMac;
            default: opc = mulPkg::opLdAcc;
        endcase
        rnd = nextRandom();
        if (opc == mulPkg::opLdAcc)
            addRow(makeLoad(rnd));
        else
            addRow(makeOp(opc, rnd[31:16], rnd[15:0]));
    end

    // Reset may still be unknown at time zero
    waitCnt = 0;
    while (rstN !== 1'b1 && waitCnt < 10)
    begin
        @(posedge clk);
        waitCnt++;
    end
    assert (rstN === 1'b1)
    else
    begin
        $display("Reset was never released");
        stopOnError();
    end

    foreach (rows[k])
    begin
        pulseStart(rows[k].cmd);
        waitDone(lat);
        opc    = rows[k].cmd.opv.opcode;
        expLat = (opc == mulPkg::opMul || opc == mulPkg::opMulU || opc == mulPkg::opMac) ?
                 mulLatency : shortLatency;
        checkValue("done latency", lat, expLat);
        checkValue("result", result, rows[k].expRes);
        checkValue("cmdErr", cmdErr, rows[k].expErr);
        checkValue("accOvf", accOvf, rows[k].expOvf);
        checkBoundAsserts();
    end

    // Second start lands mid-operation and must vanish
    pulseStart(makeOp(mulPkg::opMul, 16'h1234, 16'h0010));
    repeat (5) @(negedge clk);
    pulseStart(makeLoad(32'hDEAD_BEEF));
    waitDone(lat);
    checkValue("result", result, 32'h0001_2340);
    checkValue("cmdErr", cmdErr, 1'b0);
    repeat (30)
    begin
        @(negedge clk);
        assert (!done)
        else
        begin
            $display("Extra done after a start given while busy");
            stopOnError();
        end
    end

    if (dut.uChk.errCount == 0)
    begin
        $display("TEST PASSED");
        $finish;
    end
    else
    begin
        $display("Bound checker reported %0d assertion failures", dut.uChk.errCount);
        stopOnError();
    end
end

endmodule

/* all.f */
common/mulPkg.sv
design/cmdDecode.sv
booth/boothCore.sv
design/accResult.sv
design/mulUnit.sv
tests/clkGen.sv
tests/mulUnit_chk.sv
tests/mulUnitTb.sv
